// ==== run.sh ====
#!/bin/sh
# compile and run the quantizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Some tests failed"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module quantizer_tb -f sim.f -o quantizer_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/quantizer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "simulation PASSED"
exit 0

// ==== sim.f ====
verilog/quant_coef_pkg.sv
verilog/quant_table_pkg.sv
verilog/quant_table_ram.sv
verilog/quant_datapath.sv
verilog/zigzag_order.sv
verilog/reorder_buffer.sv
verilog/quantizer_top.sv
tb/tb_clock.sv
tb/quantizer_props.sv
tb/quantizer_tb.sv

// ==== tb/quantizer_props.sv ====
////////////////////////////////////////////////////////////
// quantizer output protocol assertions
// block start and valid strobes, quiet during reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module quantizer_props (
   input logic clk,
   input logic i_arst_n,
   input logic i_ds,    // o_ds of the quantizer
   input logic i_dv     // o_dv of the quantizer
);

   logic [6:0] dv_left; // beats still owed after the last o_ds

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         dv_left <= '0;
      end else if (i_ds) begin
         dv_left <= 7'd64; // a new block restarts the count
      end else if (dv_left != '0) begin
         dv_left <= dv_left - 7'd1;
      end
   end

   ds_then_dv: assert property (@(posedge clk) disable iff (!i_arst_n)
      (dv_left != '0) |-> i_dv)
      else $error("o_dv dropped before 64 beats after o_ds");

   dv_rise_after_ds: assert property (@(posedge clk) disable iff (!i_arst_n)
      $rose(i_dv) |-> $past(i_ds))
      else $error("o_dv rose without o_ds in the cycle before");

   quiet_in_reset: assert property (@(posedge clk) !i_arst_n |-> (!i_ds && !i_dv))
      else $error("output strobe high during reset");

endmodule

bind quantizer_top quantizer_props i_quantizer_props (
   .clk      (clk),
   .i_arst_n (i_arst_n),
   .i_ds     (o_ds),
   .i_dv     (o_dv)
);

// ==== tb/quantizer_tb.sv ====
////////////////////////////////////////////////////////////
// JPEG quantizer testbench
// LFSR driven blocks and tables, a model of the scaling,
// rounding and zigzag order, and strobe timing checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module quantizer_tb;

   import quant_coef_pkg::*;
   import quant_table_pkg::*;

   localparam int TABLE_WORDS    = 2 ** TADDR_W;
   localparam int START_TO_DS    = 69; // i_start to o_ds in cycles
   localparam int NUM_RANDOM     = 8;
   localparam int NUM_BLOCKS     = NUM_RANDOM + 6;
   localparam int NUM_REWRITES   = 8;
   localparam int IDENT_TABLE    = 15; // every entry 0xffff
   localparam int REWRITE_TABLE  = 14;
   localparam int KIND_RANDOM    = 0;
   localparam int KIND_RAMP      = 1;
   localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_LEN + TABLE_WORDS + 200;

   // row-major position for each zigzag output position
   localparam int ZIGZAG [BLOCK_LEN] = '{
       0,  1,  8, 16,  9,  2,  3, 10, 17, 24, 32, 25, 18, 11,  4,  5,
      12, 19, 26, 33, 40, 48, 41, 34, 27, 20, 13,  6,  7, 14, 21, 28,
      35, 42, 49, 56, 57, 50, 43, 36, 29, 22, 15, 23, 30, 37, 44, 51,
      58, 59, 52, 45, 38, 31, 39, 46, 53, 60, 61, 54, 47, 55, 62, 63
   };

   logic   clk;
   logic   i_arst_n;
   logic   i_start;
   coef_t  i_di;
   dc_t    i_dc;
   tsel_t  i_tsel;
   logic   i_ctype;
   logic   i_twe;
   taddr_t i_ta;
   qcoef_t i_tdi;
   logic   o_ds;
   logic   o_dv;
   coef_t  o_do;

   logic [15:0] lfsr = 16'd10;
   qcoef_t      model_tab [TABLE_WORDS]; // model copy of all tables
   coef_t       exp_q [$];               // expected outputs, zigzag order
   int          start_q [$];             // i_start cycle of each pending block
   int          cyc = 0;
   logic        active = 1'b0;           // output block being received
   pos_t        out_pos = '0;            // next zigzag position due
   int          blk_out = 0;
   coef_t       exp_val;

   tb_clock i_tb_clock (
      .clk      (clk),
      .o_arst_n (i_arst_n)
   );

   quantizer_top i_quantizer_top (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_start  (i_start),
      .i_di     (i_di),
      .i_dc     (i_dc),
      .i_tsel   (i_tsel),
      .i_ctype  (i_ctype),
      .i_twe    (i_twe),
      .i_ta     (i_ta),
      .i_tdi    (i_tdi),
      .o_ds     (o_ds),
      .o_dv     (o_dv),
      .o_do     (o_do)
   );

   task automatic stop_with_failure();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_coef(input coef_t got, input coef_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_pos(input pos_t got, input pos_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_cycle(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("MISMATCH at %0t: %s in cycle %0d, expected %0d", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   // galois lfsr x^16+x^14+x^13+x^11+1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr); // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic write_entry(input taddr_t a, input qcoef_t v);
      @(posedge clk);
      i_twe <= 1'b1;
      i_ta  <= a;
      i_tdi <= v;
      model_tab[a] = v;
   endtask

   task automatic load_tables();
      qcoef_t v;
      for (int a = 0; a < TABLE_WORDS; a++) begin
         v = (a / BLOCK_LEN == IDENT_TABLE) ? 16'hFFFF : qcoef_t'(random_bits(QCOEF_W));
         write_entry(taddr_t'(a), v);
      end
      @(posedge clk);
      i_twe <= 1'b0;
   endtask

   // one block of 64 coefficients, optionally rewriting table 14 on the way
   task automatic send_block(input int kind, input dc_t dc, input tsel_t tsel,
                             input logic ctype, input logic rewrite);
      coef_t       di [BLOCK_LEN];
      int          tidx;
      int          p;
      int          k;
      int          x;
      longint      r;
      logic [31:0] mag;
      taddr_t      wa;
      qcoef_t      wv;
      tidx = int'({tsel, ctype});
      for (int i = 0; i < BLOCK_LEN; i++) begin
         if (kind == KIND_RAMP) begin
            di[i] = coef_t'(i * 3 - 90); // distinct values, one of them zero
         end else begin
            mag   = random_bits(11); // leaves room for the dc add
            di[i] = (random_bits(1) != 0) ? -coef_t'(mag) : coef_t'(mag);
         end
      end
      for (int j = 0; j < BLOCK_LEN; j++) begin
         p = ZIGZAG[j];
         k = (p % 8) * 8 + p / 8; // input comes column-major
         x = int'(di[k]);
         if (k == 0) begin
            x = x + int'(dc) * (2 ** DC_SHIFT);
         end
         r = longint'(x < 0 ? -x : x) * longint'(model_tab[tidx * BLOCK_LEN + p]);
         r = (r + 32768) >>> 16; // round to nearest
         exp_q.push_back(x < 0 ? -coef_t'(r) : coef_t'(r));
      end
      for (int i = 0; i < BLOCK_LEN; i++) begin
         @(posedge clk);
         if (i == 0) begin
            start_q.push_back(cyc + 1); // cycle in which i_start is high
         end
         i_start <= (i == 0);
         i_di    <= di[i];
         i_dc    <= dc;
         i_tsel  <= tsel;
         i_ctype <= ctype;
         if (rewrite && i >= 8 && i < 8 + NUM_REWRITES) begin
            wa = taddr_t'(REWRITE_TABLE * BLOCK_LEN) | taddr_t'(random_bits(POS_W));
            wv = qcoef_t'(random_bits(QCOEF_W));
            i_twe <= 1'b1;
            i_ta  <= wa;
            i_tdi <= wv;
            model_tab[wa] = wv;
         end else begin
            i_twe <= 1'b0;
         end
      end
   endtask

   // outputs sampled mid-cycle, beat handled before a new block start
   always @(negedge clk) begin
      if (i_arst_n) begin
         if (active && !o_dv) begin
            $display("ERROR at %0t: o_dv went low in the middle of block %0d", $time, blk_out);
            stop_with_failure();
         end else if (o_dv) begin
            if (!active || exp_q.size() == 0) begin
               $display("ERROR at %0t: o_dv is high with no output block in progress", $time);
               stop_with_failure();
            end else begin
               exp_val = exp_q.pop_front();
               check_coef(o_do, exp_val,
                          $sformatf("block %0d zigzag position %0d", blk_out, out_pos));
               if (out_pos == pos_t'(BLOCK_LEN - 1)) begin
                  active = 1'b0;
                  blk_out++;
               end
               out_pos = out_pos + pos_t'(1);
            end
         end
         if (o_ds) begin
            if (start_q.size() == 0) begin
               $display("ERROR at %0t: o_ds arrived while no block was due", $time);
               stop_with_failure();
            end else begin
               check_cycle(cyc, start_q.pop_front() + START_TO_DS, "o_ds after i_start");
               check_pos(out_pos, '0, "positions delivered before this o_ds");
               active = 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("ERROR: the run hung, not finished after %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   initial begin
      tsel_t tsel;
      logic  ctype;
      i_start <= 1'b0;
      i_di    <= '0;
      i_dc    <= '0;
      i_tsel  <= '0;
      i_ctype <= 1'b0;
      i_twe   <= 1'b0;
      i_ta    <= '0;
      i_tdi   <= '0;
      do @(posedge clk); while (!i_arst_n);
      load_tables();
      // identity table shows zigzag order and the plain dc add
      send_block(KIND_RAMP, '0, tsel_t'(IDENT_TABLE >> 1), 1'b1, 1'b0);
      send_block(KIND_RANDOM, dc_t'(-37), tsel_t'(IDENT_TABLE >> 1), 1'b1, 1'b0);
      send_block(KIND_RANDOM, dc_t'(100), 3'd2, 1'b0, 1'b0);
      for (int b = 0; b < NUM_RANDOM; b++) begin
         tsel  = tsel_t'(random_bits(TSEL_W));
         ctype = random_bits(1) != 0;
         if ({tsel, ctype} == 4'(REWRITE_TABLE)) begin
            ctype = 1'b1; // table 14 is kept for the rewrite blocks
         end
         send_block(KIND_RANDOM, dc_t'(random_bits(DC_W)), tsel, ctype, 1'b0);
      end
      // table 14 used, rewritten during the next block, used again
      send_block(KIND_RANDOM, dc_t'(random_bits(DC_W)), tsel_t'(REWRITE_TABLE >> 1), 1'b0, 1'b0);
      send_block(KIND_RANDOM, '0, 3'd3, 1'b1, 1'b1);
      send_block(KIND_RANDOM, dc_t'(random_bits(DC_W)), tsel_t'(REWRITE_TABLE >> 1), 1'b0, 1'b0);
      while (active || exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      if (start_q.size() == 0 && exp_q.size() == 0 && !active) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("ERROR: blocks still owed output at the end of the run");
         stop_with_failure();
      end
   end

endmodule

// ==== tb/tb_clock.sv ====
////////////////////////////////////////////////////////////
// testbench clock and reset
// 20 ns clock, reset held low for the first 3 cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic o_arst_n
);

   localparam int HALF_PERIOD = 10; // ns
   localparam int RST_CYCLES  = 3;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      o_arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      o_arst_n <= 1'b1; // released on an edge, flops leave reset next cycle
   end

endmodule

// ==== verilog/quant_coef_pkg.sv ====
////////////////////////////////////////////////////////////
// coefficient package for the JPEG quantizer
// widths of DCT coefficients, magnitudes and block average,
// and the 8x8 block geometry
////////////////////////////////////////////////////////////

package quant_coef_pkg;

   localparam int COEF_W    = 13; // signed coefficient in and out
   localparam int MAG_W     = 12; // magnitude after sign split
   localparam int DC_W      = 9;  // signed block average
   localparam int DC_SHIFT  = 3;  // average is scaled up before the add
   localparam int BLOCK_LEN = 64; // 8x8 block
   localparam int POS_W     = 6;  // position inside a block

   typedef logic signed [COEF_W-1:0] coef_t;
   typedef logic        [MAG_W-1:0]  mag_t;
   typedef logic        [POS_W-1:0]  pos_t;
   typedef logic signed [DC_W-1:0]   dc_t;

endpackage

// ==== verilog/quant_datapath.sv ====
////////////////////////////////////////////////////////////
// quantizer arithmetic pipeline
// restores the block average on coefficient 0, splits sign
// and magnitude, scales by the table entry with rounding to
// nearest and puts the sign back, 4 cycles input to output
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module quant_datapath (
   input  logic                    clk,
   input  logic                    i_arst_n,
   input  logic                    i_start,  // first coefficient of a block
   input  quant_coef_pkg::coef_t   i_di,     // column-major DCT output
   input  quant_coef_pkg::dc_t     i_dc,     // block average, valid with i_start
   input  quant_table_pkg::tsel_t  i_tsel,   // quality select, valid with i_start
   input  logic                    i_ctype,  // luma/chroma, valid with i_start
   input  quant_table_pkg::qcoef_t i_q,      // table entry from memory
   output quant_table_pkg::taddr_t o_ra,     // table read address
   output logic                    o_qv,     // quantized value strobe
   output quant_coef_pkg::coef_t   o_qdo,    // quantized coefficient
   output quant_coef_pkg::pos_t    o_idx     // its column-major index
);

   import quant_coef_pkg::*;
   import quant_table_pkg::*;

   localparam int                PROD_W   = MAG_W + QCOEF_W;
   localparam logic [PROD_W-1:0] ROUND_HALF = PROD_W'(1) << (QCOEF_W - 1);
   localparam pos_t              LAST_POS = pos_t'(BLOCK_LEN - 1);

   // stage 1, input register
   coef_t d1;
   dc_t   dc1;        // average, nonzero only next to coefficient 0
   logic  start_s1;   // start delayed to line up with d1
   logic [TABLE_IDX_W-1:0] tidx_s1; // table index caught at i_start
   // stage 2, average restored
   coef_t d2;
   pos_t  cnt;        // coefficient number of d2
   logic  run_s2;
   logic [TABLE_IDX_W-1:0] tidx_s2; // switches only when the new block reaches d2
   // stage 3, sign and magnitude next to the table entry
   logic  sign_s3;
   mag_t  mag_s3;
   logic  vld_s3;
   pos_t  idx_s3;
   // scaled magnitude
   logic [PROD_W-1:0] prod;
   mag_t              r;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         start_s1 <= 1'b0;
         tidx_s1  <= '0;
         tidx_s2  <= '0;
         cnt      <= '0;
         run_s2   <= 1'b0;
         vld_s3   <= 1'b0;
         o_qv     <= 1'b0;
      end else begin
         start_s1 <= i_start;
         if (i_start) begin
            tidx_s1 <= {i_tsel, i_ctype}; // component flag is the lsb
         end
         if (start_s1) begin
            tidx_s2 <= tidx_s1;
            cnt     <= '0;
            run_s2  <= 1'b1;
         end else if (run_s2) begin
            cnt <= cnt + pos_t'(1); // wraps to 0 after the last one
            if (cnt == LAST_POS) begin
               run_s2 <= 1'b0;
            end
         end
         vld_s3 <= run_s2;
         o_qv   <= vld_s3;
      end
   end

   // coefficient k sits at row k[2:0], column k[5:3]; tables are row-major
   assign o_ra = {tidx_s2, cnt[2:0], cnt[5:3]};

   // m*q with half an lsb added, then drop the 16 fractional bits
   assign prod = PROD_W'(mag_s3) * PROD_W'(i_q) + ROUND_HALF;
   assign r    = prod[QCOEF_W +: MAG_W];

   always_ff @(posedge clk) begin
      d1      <= i_di;
      dc1     <= i_start ? i_dc : '0;
      d2      <= d1 + (coef_t'(dc1) <<< DC_SHIFT); // average back on coefficient 0
      sign_s3 <= d2[COEF_W-1];
      mag_s3  <= d2[COEF_W-1] ? mag_t'(-d2) : mag_t'(d2);
      idx_s3  <= cnt;
      o_idx   <= idx_s3;
      // a zero result stays positive zero
      o_qdo   <= (sign_s3 && (r != '0)) ? -coef_t'(r) : coef_t'(r);
   end

endmodule

// ==== verilog/quant_table_pkg.sv ====
////////////////////////////////////////////////////////////
// quantization table package
// entry width, table select and table memory addressing
////////////////////////////////////////////////////////////

package quant_table_pkg;

   localparam int QCOEF_W     = 16; // multiplier, all 16 bits fractional
   localparam int TSEL_W      = 3;  // quality select
   localparam int TABLE_IDX_W = 4;  // {quality, luma/chroma}
   // table index sits above the entry number
   localparam int TADDR_W     = TABLE_IDX_W + quant_coef_pkg::POS_W;

   typedef logic [QCOEF_W-1:0] qcoef_t;
   typedef logic [TADDR_W-1:0] taddr_t;
   typedef logic [TSEL_W-1:0]  tsel_t;

endpackage

// ==== verilog/quant_table_ram.sv ====
////////////////////////////////////////////////////////////
// quantization table memory
// 16 tables of 64 entries, written one word per clock,
// read through a registered port that feeds the multiplier
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module quant_table_ram (
   input  logic                    clk,
   input  logic                    i_twe,  // table write strobe
   input  quant_table_pkg::taddr_t i_ta,   // write address {table, entry}
   input  quant_table_pkg::qcoef_t i_tdi,  // write data
   input  quant_table_pkg::taddr_t i_ra,   // read address from datapath
   output quant_table_pkg::qcoef_t o_q     // entry, one cycle after i_ra
);

   import quant_table_pkg::*;

   localparam int DEPTH = 2 ** TADDR_W; // all tables in one array

   qcoef_t mem [DEPTH];

   // write port, entry is visible to reads starting next cycle
   always_ff @(posedge clk) begin
      if (i_twe) begin
         mem[i_ta] <= i_tdi;
      end
   end

   // read port always enabled, address changes every coefficient
   always_ff @(posedge clk) begin
      o_q <= mem[i_ra];
   end

endmodule

// ==== verilog/quantizer_top.sv ====
////////////////////////////////////////////////////////////
// JPEG quantizer
// scales 8x8 DCT blocks by a selectable quantization table
// and emits them in zigzag order, two blocks in flight
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module quantizer_top (
   input  logic                    clk,
   input  logic                    i_arst_n,
   input  logic                    i_start,  // with coefficient 0 of a block
   input  quant_coef_pkg::coef_t   i_di,     // DCT coefficients, column-major
   input  quant_coef_pkg::dc_t     i_dc,     // block average
   input  quant_table_pkg::tsel_t  i_tsel,   // quality select
   input  logic                    i_ctype,  // luma/chroma flag
   input  logic                    i_twe,    // table write strobe
   input  quant_table_pkg::taddr_t i_ta,     // table write address
   input  quant_table_pkg::qcoef_t i_tdi,    // table write data
   output logic                    o_ds,     // output block start
   output logic                    o_dv,     // output valid
   output quant_coef_pkg::coef_t   o_do      // quantized data, zigzag order
);

   import quant_coef_pkg::*;
   import quant_table_pkg::*;

   taddr_t tab_ra;   // table read address
   qcoef_t tab_q;    // table entry
   logic   q_v;      // datapath result strobe
   coef_t  q_do;
   pos_t   q_idx;    // column-major index of q_do
   logic   zz_we;
   pos_t   zz_wa;    // zigzag write address
   coef_t  zz_wd;

   quant_table_ram i_quant_table_ram (
      .clk   (clk),
      .i_twe (i_twe),
      .i_ta  (i_ta),
      .i_tdi (i_tdi),
      .i_ra  (tab_ra),
      .o_q   (tab_q)
   );

   quant_datapath i_quant_datapath (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_start  (i_start),
      .i_di     (i_di),
      .i_dc     (i_dc),
      .i_tsel   (i_tsel),
      .i_ctype  (i_ctype),
      .i_q      (tab_q),
      .o_ra     (tab_ra),
      .o_qv     (q_v),
      .o_qdo    (q_do),
      .o_idx    (q_idx)
   );

   zigzag_order i_zigzag_order (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_qv     (q_v),
      .i_idx    (q_idx),
      .i_qdo    (q_do),
      .o_we     (zz_we),
      .o_wa     (zz_wa),
      .o_wd     (zz_wd)
   );

   reorder_buffer #(
      .NUM_PAGES_LOG (1) // double buffer
   ) i_reorder_buffer (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_we     (zz_we),
      .i_wa     (zz_wa),
      .i_wd     (zz_wd),
      .o_ds     (o_ds),
      .o_dv     (o_dv),
      .o_do     (o_do)
   );

endmodule

// ==== verilog/reorder_buffer.sv ====
////////////////////////////////////////////////////////////
// zigzag reorder buffer
// paged coefficient memory, one page filled in zigzag order
// while the previous one is read out sequentially
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer #(
   parameter int NUM_PAGES_LOG = 1 // log2 of the number of pages
) (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_we,   // write strobe
   input  quant_coef_pkg::pos_t  i_wa,   // zigzag position
   input  quant_coef_pkg::coef_t i_wd,   // quantized value
   output logic                  o_ds,   // block start, one ahead of o_dv
   output logic                  o_dv,   // output valid
   output quant_coef_pkg::coef_t o_do    // coefficient in zigzag order
);

   import quant_coef_pkg::*;

   localparam int   DEPTH    = BLOCK_LEN << NUM_PAGES_LOG;
   localparam pos_t LAST_POS = pos_t'(BLOCK_LEN - 1);

   coef_t                    mem [DEPTH];
   logic [NUM_PAGES_LOG-1:0] wpage;   // page being filled
   logic [NUM_PAGES_LOG-1:0] rpage;   // page being read
   pos_t                     ra;      // read position
   logic                     rd_run;  // read address valid this cycle
   logic                     wr_last; // last position of a block written

   // zigzag position 63 is always the final write of a block
   assign wr_last = i_we && (i_wa == LAST_POS);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wpage  <= '0;
         rpage  <= '0;
         ra     <= '0;
         rd_run <= 1'b0;
         o_ds   <= 1'b0;
         o_dv   <= 1'b0;
      end else begin
         o_ds <= wr_last;
         o_dv <= rd_run; // data comes a cycle after its address
         if (wr_last) begin
            rpage  <= wpage; // hand the full page to the reader
            wpage  <= wpage + NUM_PAGES_LOG'(1);
            ra     <= '0;
            rd_run <= 1'b1;
         end else if (rd_run) begin
            ra <= ra + pos_t'(1);
            if (ra == LAST_POS) begin
               rd_run <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_we) begin
         mem[{wpage, i_wa}] <= i_wd;
      end
   end

   // read only while a page is being emitted
   always_ff @(posedge clk) begin
      if (rd_run) begin
         o_do <= mem[{rpage, ra}];
      end
   end

endmodule

// ==== verilog/zigzag_order.sv ====
////////////////////////////////////////////////////////////
// zigzag addressing for the reorder buffer
// turns the column-major coefficient index into its JPEG
// zigzag position and registers it with data and strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module zigzag_order (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_qv,   // quantized value strobe
   input  quant_coef_pkg::pos_t  i_idx,  // column-major index
   input  quant_coef_pkg::coef_t i_qdo,  // quantized value
   output logic                  o_we,   // reorder buffer write
   output quant_coef_pkg::pos_t  o_wa,   // zigzag position
   output quant_coef_pkg::coef_t o_wd    // data to write
);

   import quant_coef_pkg::*;

   logic [8*POS_W-1:0] zz_row; // zigzag numbers of one row, column 7 leftmost
   pos_t               zz_pos;

   // row of a column-major index is its low 3 bits
   always_comb begin
      case (i_idx[2:0])
         3'd0: zz_row = {6'd28, 6'd27, 6'd15, 6'd14, 6'd6,  6'd5,  6'd1,  6'd0};
         3'd1: zz_row = {6'd42, 6'd29, 6'd26, 6'd16, 6'd13, 6'd7,  6'd4,  6'd2};
         3'd2: zz_row = {6'd43, 6'd41, 6'd30, 6'd25, 6'd17, 6'd12, 6'd8,  6'd3};
         3'd3: zz_row = {6'd53, 6'd44, 6'd40, 6'd31, 6'd24, 6'd18, 6'd11, 6'd9};
         3'd4: zz_row = {6'd54, 6'd52, 6'd45, 6'd39, 6'd32, 6'd23, 6'd19, 6'd10};
         3'd5: zz_row = {6'd60, 6'd55, 6'd51, 6'd46, 6'd38, 6'd33, 6'd22, 6'd20};
         3'd6: zz_row = {6'd61, 6'd59, 6'd56, 6'd50, 6'd47, 6'd37, 6'd34, 6'd21};
         3'd7: zz_row = {6'd63, 6'd62, 6'd58, 6'd57, 6'd49, 6'd48, 6'd36, 6'd35};
         default: zz_row = '0;
      endcase
   end

   assign zz_pos = zz_row[i_idx[5:3]*POS_W +: POS_W]; // column picks the entry

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_we <= 1'b0;
      end else begin
         o_we <= i_qv; // strobe follows the registered address
      end
   end

   always_ff @(posedge clk) begin
      o_wa <= zz_pos;
      o_wd <= i_qdo;
   end

endmodule
